//--- tb.f
+incdir+testbench
hdl/ddc_sample_pkg.sv
hdl/ddc_ctrl_pkg.sv
hdl/nco_phase_accum.sv
hdl/cordic_rotator.sv
hdl/boxcar_decimator.sv
hdl/ddc_top.sv
testbench/tb_ddc.sv

//--- Bender.yml
package:
  name: ddc_frontend

sources:
  - hdl/ddc_sample_pkg.sv
  - hdl/ddc_ctrl_pkg.sv
  - hdl/nco_phase_accum.sv
  - hdl/cordic_rotator.sv
  - hdl/boxcar_decimator.sv
  - hdl/ddc_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_ddc.sv

//--- testbench/tb_ddc_checks.svh
`ifndef TB_DDC_CHECKS_SVH
`define TB_DDC_CHECKS_SVH

   localparam real PI     = 3.14159265358979;
   localparam real G_CORD = 3.29352;   // 2 x gain of 17 micro-rotations

   // Nearest integer, halves away from zero
   function automatic int round_real(input real r);
      return (r >= 0.0) ? $rtoi(r + 0.5) : -$rtoi(0.5 - r);
   endfunction

   // Ideal sum of sent[first..first+n-1] turned by e^(j*2*pi*phase/2^20)
   function automatic iq_sum_t model_group(input int first, input int n,
                                           input phase_t off, input phase_t frq);
      real     a;
      real     si;
      real     sq;
      phase_t  ph;
      iq_sum_t r;
      int      k;
      si = 0.0;
      sq = 0.0;
      for (k = first; k < first + n; k++) begin
         ph = off + phase_t'(k) * frq;       // Phase counted from the clear
         a  = 2.0 * PI * $itor(ph) / 1048576.0;
         si += G_CORD * ($itor(sent[k].i) * $cos(a) - $itor(sent[k].q) * $sin(a));
         sq += G_CORD * ($itor(sent[k].i) * $sin(a) + $itor(sent[k].q) * $cos(a));
      end
      r.i = SUM_W'(round_real(si));
      r.q = SUM_W'(round_real(sq));
      return r;
   endfunction

   task automatic compare_sum(input string name, input iq_sum_t exp, input iq_sum_t act,
                              input int tol);
      int di;
      int dq;
      di = act.i - exp.i;
      dq = act.q - exp.q;
      if (di > tol || -di > tol) begin
         $display("[ERROR] %s out_sample.i: expected %h, got %h", name, exp.i, act.i);
         err_cnt++;
      end
      if (dq > tol || -dq > tol) begin
         $display("[ERROR] %s out_sample.q: expected %h, got %h", name, exp.q, act.q);
         err_cnt++;
      end
   endtask

   task automatic compare_latency(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("%s: out_valid came %0d cycles after the last in_valid, not %0d",
                  name, act, exp);
         err_cnt++;
      end
   endtask

   // Any strobe inside the window is a failure
   task automatic check_no_output(input string name, input int n);
      repeat (n) @(posedge clk);
      if (out_q.size() != 0) begin
         $display("%s: %0d unexpected outputs during a quiet period", name, out_q.size());
         err_cnt++;
         out_q.delete();
         cyc_q.delete();
      end
   endtask

`endif

//--- testbench/tb_ddc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ddc;

   import ddc_sample_pkg::*;
   import ddc_ctrl_pkg::*;

   localparam int DECIM      = 8;
   localparam int MAX_CYCLES = 4000;   // Tests need about 700 cycles
   localparam int OUT_WAIT   = 60;     // Per wait, latency is 20

   logic        clk = 1'b0;
   logic        arst_n;
   nco_cmd_t    cmd;
   logic        in_valid;
   iq_sample_t  in_sample;
   logic        out_valid;
   iq_sum_t     out_sample;

   int          cycle   = 0;      // Rising edges so far
   int          err_cnt = 0;
   int          n_pass  = 0;
   int          n_fail  = 0;
   int          n_sent;           // Samples since the last clear
   int          last_in_cyc;      // Cycle of the latest in_valid
   logic [31:0] lfsr = 32'h25a2;
   iq_sample_t  sent [0:63];      // Indexed by position after the clear
   iq_sum_t     out_q [$];        // Captured output samples
   int          cyc_q [$];        // Cycle of each capture

   ddc_top #(.DECIM(DECIM)) i_dut (
      .clk(clk), .arst_n(arst_n), .cmd(cmd), .in_valid(in_valid),
      .in_sample(in_sample), .out_valid(out_valid), .out_sample(out_sample)
   );

   always #4 clk = ~clk;   // 8 ns

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Some tests failed");
         $finish;
      end
   end

   // Outputs settled by the falling edge
   always @(negedge clk) begin
      if (arst_n && out_valid) begin
         out_q.push_back(out_sample);
         cyc_q.push_back(cycle);
      end
   end

   // Galois LFSR, one step per bit
   function automatic logic lfsr_step();
      logic b;
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h8020_0003;
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      repeat (n) v = {v[30:0], lfsr_step()};
      return v;
   endfunction

   function automatic logic signed [15:0] rand_comp();
      logic [31:0]        b;
      logic signed [15:0] r;
      int                 v;
      b = rand_bits(16);
      r = b[15:0];
      v = r;
      v = v % 20001;   // Within +-20000, rotator registers stay in range
      return v[15:0];
   endfunction

   function automatic iq_sample_t rand_sample();
      iq_sample_t r;
      r.i = rand_comp();
      r.q = rand_comp();
      return r;
   endfunction

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic send_cmd(input nco_op_e op, input phase_t data);
      step();
      cmd.op   = op;
      cmd.data = data;
      step();
      cmd.op   = NOP;
   endtask

   task automatic restart(input phase_t frq, input phase_t off);
      send_cmd(SET_FREQ, frq);
      send_cmd(SET_OFFSET, off);
      send_cmd(CLEAR_PHASE, '0);
      n_sent = 0;
   endtask

   // Consecutive samples, constant s or fresh random ones
   task automatic send_samples(input int n, input iq_sample_t s, input logic rnd);
      repeat (n) begin
         step();
         in_valid       = 1'b1;
         in_sample      = rnd ? rand_sample() : s;
         sent[n_sent]   = in_sample;
         n_sent++;
         last_in_cyc    = cycle;
      end
      step();
      in_valid = 1'b0;
   endtask

   task automatic wait_outputs(input string name, input int n);
      int waited;
      waited = 0;
      while (out_q.size() < n && waited < OUT_WAIT) begin
         @(posedge clk);
         waited++;
      end
      if (out_q.size() < n) begin
         $display("%s: only %0d of %0d outputs arrived within %0d cycles",
                  name, out_q.size(), n, OUT_WAIT);
         err_cnt++;
      end
   endtask

   task automatic take_output(output iq_sum_t s, output int c);
      s = (out_q.size() != 0) ? out_q.pop_front() : '0;
      c = (cyc_q.size() != 0) ? cyc_q.pop_front() : -1;
   endtask

   task automatic end_test(input string name, input int err_before);
      if (err_cnt == err_before) begin
         n_pass++;
         $display("%s: pass", name);
      end else begin
         n_fail++;
         $display("%s: FAIL, %0d errors", name, err_cnt - err_before);
      end
   endtask

   task automatic reset_idle();
      int e0;
      e0 = err_cnt;
      check_no_output("reset_idle", 40);
      end_test("reset_idle", e0);
   endtask

   task automatic zero_phase_gain();
      int         e0;
      int         c;
      iq_sample_t s;
      iq_sum_t    act;
      e0 = err_cnt;
      s  = rand_sample();
      restart('0, '0);
      send_samples(8, s, 1'b0);
      wait_outputs("zero_phase_gain", 1);
      take_output(act, c);
      compare_sum("zero_phase_gain", model_group(0, 8, '0, '0), act, 32);
      compare_latency("zero_phase_gain", 20, c - last_in_cyc);
      end_test("zero_phase_gain", e0);
   endtask

   task automatic offset_quadrants();
      int         e0;
      int         c;
      iq_sample_t s;
      iq_sum_t    act;
      phase_t     off;
      e0 = err_cnt;
      s  = rand_sample();
      for (int k = 0; k < 4; k++) begin
         off = (k < 3) ? phase_t'((k + 1) * 32'h40000) : phase_t'(rand_bits(20));
         restart('0, off);
         send_samples(8, s, 1'b0);
         wait_outputs("offset_quadrants", 1);
         take_output(act, c);
         compare_sum("offset_quadrants", model_group(0, 8, off, '0), act, 32);
      end
      end_test("offset_quadrants", e0);
   endtask

   task automatic freq_tuning();
      int         e0;
      int         c;
      iq_sample_t s;
      iq_sum_t    a1;
      iq_sum_t    a2;
      iq_sum_t    exp1;
      iq_sum_t    neg;
      e0 = err_cnt;
      s  = rand_sample();
      restart(20'h20000, '0);   // Full turn per group
      send_samples(8, s, 1'b0);
      wait_outputs("freq_tuning", 1);
      take_output(a1, c);
      compare_sum("freq_tuning", '0, a1, 64);
      restart(20'h10000, '0);   // Half turn per group
      send_samples(16, s, 1'b0);
      wait_outputs("freq_tuning", 2);
      take_output(a1, c);
      take_output(a2, c);
      exp1  = model_group(0, 8, '0, 20'h10000);
      neg.i = -exp1.i;          // Second group sits half a turn later
      neg.q = -exp1.q;
      compare_sum("freq_tuning", exp1, a1, 64);
      compare_sum("freq_tuning", neg, a2, 64);
      end_test("freq_tuning", e0);
   endtask

   task automatic stream_back_to_back();
      int         e0;
      int         c;
      iq_sum_t    act;
      phase_t     frq;
      e0  = err_cnt;
      frq = phase_t'(rand_bits(20));
      restart(frq, '0);
      send_samples(32, '0, 1'b1);
      wait_outputs("stream_back_to_back", 4);
      for (int g = 0; g < 4; g++) begin
         take_output(act, c);
         compare_sum("stream_back_to_back", model_group(8 * g, 8, '0, frq), act, 64);
      end
      end_test("stream_back_to_back", e0);
   endtask

   task automatic clear_restart();
      int         e0;
      int         c;
      iq_sum_t    act;
      e0 = err_cnt;
      restart(20'h0C000, 20'h12345);
      send_samples(3, '0, 1'b1);
      check_no_output("clear_restart", 25);   // Partial group only
      send_cmd(CLEAR_PHASE, '0);
      n_sent = 0;
      send_samples(8, '0, 1'b1);
      wait_outputs("clear_restart", 1);
      take_output(act, c);
      compare_sum("clear_restart", model_group(0, 8, 20'h12345, 20'h0C000), act, 32);
      check_no_output("clear_restart", 30);
      end_test("clear_restart", e0);
   endtask

   initial begin
      arst_n      = 1'b0;
      cmd.op      = NOP;
      cmd.data    = '0;
      in_valid    = 1'b0;
      in_sample   = '0;
      n_sent      = 0;
      last_in_cyc = 0;
      repeat (2) @(posedge clk);
      #1 arst_n = 1'b1;
      reset_idle();
      zero_phase_gain();
      offset_quadrants();
      freq_tuning();
      stream_back_to_back();
      clear_restart();
      $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
      if (n_fail == 0 && err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

`include "tb_ddc_checks.svh"

endmodule

`default_nettype wire

//--- hdl/ddc_top.sv
`timescale 1ns/1ps
`default_nettype none

module ddc_top #(
   parameter int DECIM = 8   // Decimation factor, 2..64
) (
   input  logic                       clk,
   input  logic                       arst_n,
   input  ddc_ctrl_pkg::nco_cmd_t     cmd,
   input  logic                       in_valid,
   input  ddc_sample_pkg::iq_sample_t in_sample,
   output logic                       out_valid,
   output ddc_sample_pkg::iq_sum_t    out_sample
);

   import ddc_sample_pkg::*;

   phase_t  phase;        // Per-sample phase, same cycle as in_valid
   logic    phase_clr;    // Group restart pulse
   logic    rot_valid;
   iq_rot_t rot_sample;

   nco_phase_accum i_nco (
      .clk       (clk),
      .arst_n    (arst_n),
      .cmd       (cmd),
      .in_valid  (in_valid),
      .phase     (phase),
      .phase_clr (phase_clr)
   );

   cordic_rotator i_cordic (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_sample  (in_sample),
      .phase      (phase),
      .rot_valid  (rot_valid),
      .rot_sample (rot_sample)
   );

   boxcar_decimator #(
      .DECIM (DECIM)
   ) i_decim (
      .clk        (clk),
      .arst_n     (arst_n),
      .rot_valid  (rot_valid),
      .rot_sample (rot_sample),
      .phase_clr  (phase_clr),
      .out_valid  (out_valid),
      .out_sample (out_sample)
   );

endmodule

`default_nettype wire

//--- hdl/boxcar_decimator.sv
`timescale 1ns/1ps
`default_nettype none

module boxcar_decimator #(
   parameter int DECIM = 8   // Samples per output, 2..64
) (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    rot_valid,
   input  ddc_sample_pkg::iq_rot_t rot_sample,
   input  logic                    phase_clr,
   output logic                    out_valid,
   output ddc_sample_pkg::iq_sum_t out_sample
);

   import ddc_sample_pkg::*;

   localparam int CNT_W = $clog2(DECIM + 1);

   logic [CNT_W-1:0] cnt;       // Samples taken in current group
   iq_sum_t          acc;       // Partial sum
   iq_sum_t          acc_nxt;   // Partial sum incl. current sample
   logic             last;      // Current sample closes the group

   // Sign-extend and add
   always_comb begin
      acc_nxt.i = acc.i + SUM_W'(rot_sample.i);
      acc_nxt.q = acc.q + SUM_W'(rot_sample.q);
   end

   assign last = rot_valid && (cnt == CNT_W'(DECIM - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt       <= '0;
         acc       <= '0;
         out_valid <= 1'b0;
      end else begin
         out_valid <= last && !phase_clr;   // One-cycle dump strobe
         if (phase_clr) begin               // Restart group, drop partial sum
            cnt <= '0;
            acc <= '0;
         end else if (last) begin
            cnt <= '0;
            acc <= '0;                      // Next group starts clean
         end else if (rot_valid) begin
            cnt <= cnt + 1'b1;
            acc <= acc_nxt;
         end
      end
   end

   // Dump register
   always_ff @(posedge clk) begin
      if (last) begin
         out_sample <= acc_nxt;
      end
   end

   a_cnt_range: assert property (
      @(posedge clk) disable iff (!arst_n)
      cnt < DECIM
   ) else $error("boxcar_decimator: group count out of range");

   a_strobe_gap: assert property (
      @(posedge clk) disable iff (!arst_n)
      (out_valid && DECIM >= 2) |=> !out_valid
   ) else $error("boxcar_decimator: out_valid high on consecutive cycles");

endmodule

`default_nettype wire

//--- hdl/cordic_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_rotator (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       in_valid,
   input  ddc_sample_pkg::iq_sample_t in_sample,
   input  ddc_sample_pkg::phase_t     phase,
   output logic                       rot_valid,
   output ddc_sample_pkg::iq_rot_t    rot_sample
);

   import ddc_sample_pkg::*;

   // Quadrant stage + micro-rotations + rounding stage
   localparam int STAGES = CORDIC_LATENCY - 2;

   // atan(2^-k) with 45 deg = 2^17, last stage needs none
   localparam logic signed [18:0] ATAN [0:STAGES-2] = '{
      19'sd131072, 19'sd77376, 19'sd40884, 19'sd20753,
      19'sd10417,  19'sd5213,  19'sd2607,  19'sd1304,
      19'sd652,    19'sd326,   19'sd163,   19'sd81,
      19'sd41,     19'sd20,    19'sd10,    19'sd5
   };

   logic signed [19:0] x_in;   // Sign bit, 16 data bits, 3 guard bits
   logic signed [19:0] y_in;

   logic signed [19:0] x [0:STAGES];   // Real part per stage
   logic signed [19:0] y [0:STAGES];   // Imaginary part per stage
   logic signed [18:0] z [0:STAGES-1]; // Residual angle, +-90 deg max

   logic [CORDIC_LATENCY-1:0] vld_sr;  // Valid delay line

   // Drop 2 LSBs with round-half-up, 21-bit sum avoids carry loss
   function automatic logic signed [17:0] round_18(input logic signed [19:0] v);
      logic signed [20:0] s;
      s = v + 21'sd2;
      return s[19:2];
   endfunction

   assign x_in = {in_sample.i[15], in_sample.i, 3'b000};
   assign y_in = {in_sample.q[15], in_sample.q, 3'b000};

   // Quadrant stage
   // Angles in 90..270 deg get a 180 deg turn up front,
   // which leaves the residual in phase[18:0] as a signed value
   always_ff @(posedge clk) begin
      z[0] <= phase[18:0];
      case (phase[19:18])
         2'b01, 2'b10: begin
            x[0] <= -x_in;
            y[0] <= -y_in;
         end
         default: begin
            x[0] <= x_in;
            y[0] <= y_in;
         end
      endcase
   end

   // Micro-rotation stages
   for (genvar k = 0; k < STAGES; k++) begin : g_stage
      always_ff @(posedge clk) begin
         if (!z[k][18]) begin   // Residual >= 0, turn counter-clockwise
            x[k+1] <= x[k] - (y[k] >>> k);
            y[k+1] <= y[k] + (x[k] >>> k);
         end else begin         // Residual < 0, turn clockwise
            x[k+1] <= x[k] + (y[k] >>> k);
            y[k+1] <= y[k] - (x[k] >>> k);
         end
      end

      // Angle update, not needed after the last stage
      if (k < STAGES - 1) begin : g_angle
         always_ff @(posedge clk) begin
            z[k+1] <= z[k][18] ? z[k] + ATAN[k] : z[k] - ATAN[k];
         end
      end
   end

   // Output stage, 20 to 18 bits
   // Gain is 1.6468 from the micro-rotations times 2 from the guard bits
   always_ff @(posedge clk) begin
      rot_sample.i <= round_18(x[STAGES]);
      rot_sample.q <= round_18(y[STAGES]);
   end

   // Strobe follows the data through every register stage
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_sr <= '0;
      end else begin
         vld_sr <= {vld_sr[CORDIC_LATENCY-2:0], in_valid};
      end
   end

   assign rot_valid = vld_sr[CORDIC_LATENCY-1];

   // Fixed latency for every sample
   a_latency: assert property (
      @(posedge clk) disable iff (!arst_n)
      1'b1 ##CORDIC_LATENCY (rot_valid == $past(in_valid, CORDIC_LATENCY))
   ) else $error("cordic_rotator: rot_valid does not follow in_valid by %0d",
                 CORDIC_LATENCY);

endmodule

`default_nettype wire

//--- hdl/nco_phase_accum.sv
`timescale 1ns/1ps
`default_nettype none

module nco_phase_accum (
   input  logic                   clk,
   input  logic                   arst_n,
   input  ddc_ctrl_pkg::nco_cmd_t cmd,
   input  logic                   in_valid,
   output ddc_sample_pkg::phase_t phase,
   output logic                   phase_clr
);

   import ddc_sample_pkg::*;
   import ddc_ctrl_pkg::*;

   phase_t freq;     // Tuning word, phase step per sample
   phase_t offset;   // Static phase offset
   phase_t accum;    // Running phase

   // Phase for the sample now at the input
   assign phase = accum + offset;   // Wraps mod 2^20

   // Decimator restarts on the same edge as the accumulator
   assign phase_clr = (cmd.op == CLEAR_PHASE);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         freq   <= '0;
         offset <= '0;
         accum  <= '0;
      end else begin
         // Step once per accepted sample
         if (in_valid) begin
            accum <= accum + freq;
         end
         case (cmd.op)
            NOP:         ;
            SET_FREQ:    freq   <= cmd.data;
            SET_OFFSET:  offset <= cmd.data;
            CLEAR_PHASE: accum  <= '0;   // Overrides the step above
            default:     ;
         endcase
      end
   end

   // Opcode must be driven cleanly once out of reset
   a_cmd_known: assert property (
      @(posedge clk) disable iff (!arst_n)
      !$isunknown(cmd.op)
   ) else $error("nco_phase_accum: cmd.op unknown");

endmodule

`default_nettype wire

//--- hdl/ddc_ctrl_pkg.sv
`default_nettype none

package ddc_ctrl_pkg;

   // NCO command opcodes, NOP when idle
   typedef enum logic [1:0] {
      NOP         = 2'd0,
      SET_FREQ    = 2'd1,   // Load tuning word
      SET_OFFSET  = 2'd2,   // Load phase offset
      CLEAR_PHASE = 2'd3    // Zero accumulator, restart decimation
   } nco_op_e;

   // One-cycle command word
   typedef struct packed {
      nco_op_e               op;
      ddc_sample_pkg::phase_t data;   // Frequency or offset value
   } nco_cmd_t;

endpackage

`default_nettype wire

//--- hdl/ddc_sample_pkg.sv
`default_nettype none

package ddc_sample_pkg;

   // Angle word, pi rad = 2^19, wraps at 2*pi
   typedef logic [19:0] phase_t;

   // Rotator pipeline depth, input strobe to output strobe
   localparam int CORDIC_LATENCY = 19;

   // Decimator accumulator width, room for 64 rotated samples
   localparam int SUM_W = 24;

   // Baseband input sample
   typedef struct packed {
      logic signed [15:0] i;   // Real part
      logic signed [15:0] q;   // Imaginary part
   } iq_sample_t;

   // Rotator output, scaled by CORDIC gain
   typedef struct packed {
      logic signed [17:0] i;
      logic signed [17:0] q;
   } iq_rot_t;

   // Decimator output, undivided group sum
   typedef struct packed {
      logic signed [SUM_W-1:0] i;
      logic signed [SUM_W-1:0] q;
   } iq_sum_t;

endpackage

`default_nettype wire
